//--- design/gps_pkg.sv
`default_nettype none

package gps_pkg;

   // Datapath widths.
   localparam int ACC_WIDTH          = 16;
   localparam int MAG_WIDTH          = 16;
   localparam int I2Q2_WIDTH         = 33;
   localparam int PHASE_INC_WIDTH    = 32;
   localparam int STEP_COUNT_WIDTH   = 4;

   // Tracking integration length in sample strobes.
   localparam int SAMPLES_PER_ACC    = 16368;
   localparam int SAMPLE_COUNT_WIDTH = 14;
   localparam logic [SAMPLE_COUNT_WIDTH-1:0] SAMPLE_COUNT_LAST =
      SAMPLE_COUNT_WIDTH'(SAMPLES_PER_ACC - 1);

   // Magnitude queue sizing.
   localparam int FIFO_DEPTH     = 2;
   localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
   localparam logic [FIFO_PTR_WIDTH-1:0] FIFO_PTR_LAST = FIFO_PTR_WIDTH'(FIFO_DEPTH - 1);
   localparam logic [FIFO_CNT_WIDTH-1:0] FIFO_CNT_FULL = FIFO_CNT_WIDTH'(FIFO_DEPTH);

   // Saturation limits and the I2Q2 history seed.
   localparam logic signed [ACC_WIDTH-1:0] ACC_MIN = {1'b1, {(ACC_WIDTH-1){1'b0}}};
   localparam logic [MAG_WIDTH-1:0]        MAG_MAX = {1'b0, {(MAG_WIDTH-1){1'b1}}};
   localparam logic [I2Q2_WIDTH-1:0]       I2Q2_ONE = I2Q2_WIDTH'(1);

   typedef enum logic {
      MODE_IDLE,
      MODE_TRACK
   } mode_e;

   // Subchannel select, also the squaring engine state.
   typedef enum logic [1:0] {
      SUB_EARLY,
      SUB_PROMPT,
      SUB_LATE,
      ENG_IDLE
   } sub_sel_e;

   typedef struct packed {
      logic signed [ACC_WIDTH-1:0] early_i;
      logic signed [ACC_WIDTH-1:0] early_q;
      logic signed [ACC_WIDTH-1:0] prompt_i;
      logic signed [ACC_WIDTH-1:0] prompt_q;
      logic signed [ACC_WIDTH-1:0] late_i;
      logic signed [ACC_WIDTH-1:0] late_q;
   } acc_set_t;

   typedef struct packed {
      logic [MAG_WIDTH-1:0] early_i;
      logic [MAG_WIDTH-1:0] early_q;
      logic [MAG_WIDTH-1:0] prompt_i;
      logic [MAG_WIDTH-1:0] prompt_q;
      logic [MAG_WIDTH-1:0] late_i;
      logic [MAG_WIDTH-1:0] late_q;
   } mag_set_t;

   typedef struct packed {
      logic [I2Q2_WIDTH-1:0] early;
      logic [I2Q2_WIDTH-1:0] prompt;
      logic [I2Q2_WIDTH-1:0] late;
   } i2q2_set_t;

   // Values returned by the loop filters.
   typedef struct packed {
      logic [I2Q2_WIDTH-1:0]      i2q2_prompt;
      logic [PHASE_INC_WIDTH-1:0] doppler_inc;
      logic [PHASE_INC_WIDTH-1:0] code_inc;
   } loop_result_t;

   typedef struct packed {
      logic signed [ACC_WIDTH-1:0] prompt_i_k;
      logic signed [ACC_WIDTH-1:0] prompt_q_k;
      logic signed [ACC_WIDTH-1:0] prompt_i_km1;
      logic signed [ACC_WIDTH-1:0] prompt_q_km1;
      logic [I2Q2_WIDTH-1:0]       i2q2_prompt_km1;
      logic [PHASE_INC_WIDTH-1:0]  doppler_inc;
      logic [PHASE_INC_WIDTH-1:0]  code_inc;
      logic [STEP_COUNT_WIDTH-1:0] step_count;
   } track_state_t;

endpackage

`default_nettype wire

//--- design/mode_control.sv
`timescale 1ns/10ps
`default_nettype none

module mode_control (
   input  wire logic           clk,
   input  wire logic           i_arst_n,
   input  wire gps_pkg::mode_e i_mode,
   input  wire logic           i_data_available,
   output logic                o_track_start,
   output logic                o_feed_complete
);

   gps_pkg::mode_e                         mode_q;
   logic [gps_pkg::SAMPLE_COUNT_WIDTH-1:0] sample_count;
   logic                                   tracking;
   logic                                   last_sample;

   assign tracking    = (i_mode == gps_pkg::MODE_TRACK);
   assign last_sample = (sample_count == gps_pkg::SAMPLE_COUNT_LAST);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mode_q          <= gps_pkg::MODE_IDLE;
         o_track_start   <= 1'b0;
         o_feed_complete <= 1'b0;
         sample_count    <= '0;
      end else begin
         mode_q        <= i_mode;
         // Entry into tracking.
         o_track_start <= tracking && (mode_q != gps_pkg::MODE_TRACK);

         // End of integration on the last strobe of the period.
         o_feed_complete <= tracking && i_data_available && last_sample && !o_track_start;

         if (o_track_start) begin
            sample_count <= '0;
         end else if (tracking && i_data_available) begin
            sample_count <= last_sample ? '0 : sample_count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/corr_capture.sv
`timescale 1ns/10ps
`default_nettype none

module corr_capture (
   input  wire logic              clk,
   input  wire logic              i_arst_n,
   input  wire logic              i_acc_done,
   input  wire gps_pkg::acc_set_t i_acc,
   output logic                   o_push,
   output gps_pkg::mag_set_t      o_push_set
);

   // Absolute value, most negative input clipped to full scale.
   function automatic logic [gps_pkg::MAG_WIDTH-1:0] abs_sat(
      input logic signed [gps_pkg::ACC_WIDTH-1:0] value
   );
      logic [gps_pkg::MAG_WIDTH-1:0] mag;
      if (value == gps_pkg::ACC_MIN) begin
         mag = gps_pkg::MAG_MAX;
      end else if (value < 0) begin
         mag = -value;
      end else begin
         mag = value;
      end
      return mag;
   endfunction

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_push <= 1'b0;
      end else begin
         o_push <= i_acc_done;
      end
   end

   always_ff @(posedge clk) begin
      if (i_acc_done) begin
         o_push_set.early_i  <= abs_sat(i_acc.early_i);
         o_push_set.early_q  <= abs_sat(i_acc.early_q);
         o_push_set.prompt_i <= abs_sat(i_acc.prompt_i);
         o_push_set.prompt_q <= abs_sat(i_acc.prompt_q);
         o_push_set.late_i   <= abs_sat(i_acc.late_i);
         o_push_set.late_q   <= abs_sat(i_acc.late_q);
      end
   end

endmodule

`default_nettype wire

//--- design/mag_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module mag_fifo (
   input  wire logic              clk,
   input  wire logic              i_arst_n,
   input  wire logic              i_clear,
   input  wire logic              i_push,
   input  wire gps_pkg::mag_set_t i_push_set,
   input  wire logic              i_pop,
   output logic                   o_not_empty,
   output gps_pkg::mag_set_t      o_head,
   output logic                   o_overrun
);

   gps_pkg::mag_set_t                  mem [gps_pkg::FIFO_DEPTH];
   logic [gps_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
   logic [gps_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
   logic [gps_pkg::FIFO_CNT_WIDTH-1:0] count;
   logic                               full;
   logic                               do_push;
   logic                               do_pop;

   assign full        = (count == gps_pkg::FIFO_CNT_FULL);
   assign o_not_empty = (count != '0);
   assign do_push     = i_push && !full;
   assign do_pop      = i_pop && o_not_empty;
   assign o_head      = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_push_set;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         o_overrun <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == gps_pkg::FIFO_PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == gps_pkg::FIFO_PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase

         // Sticky until the next tracking entry.
         if (i_clear) begin
            o_overrun <= 1'b0;
         end else if (i_push && full) begin
            o_overrun <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/i2q2_engine.sv
`timescale 1ns/10ps
`default_nettype none

module i2q2_engine (
   input  wire logic              clk,
   input  wire logic              i_arst_n,
   input  wire logic              i_not_empty,
   input  wire gps_pkg::mag_set_t i_head,
   output logic                   o_pop,
   output logic                   o_i2q2_valid,
   output gps_pkg::i2q2_set_t     o_i2q2
);

   gps_pkg::sub_sel_e                   state;
   gps_pkg::mag_set_t                   held;
   logic                                sq_due;
   logic                                sum_due;
   logic                                load_next;
   logic [gps_pkg::MAG_WIDTH-1:0]       next_i;
   logic [gps_pkg::MAG_WIDTH-1:0]       next_q;
   logic [gps_pkg::MAG_WIDTH-1:0]       op_i;
   logic [gps_pkg::MAG_WIDTH-1:0]       op_q;
   logic [2*gps_pkg::MAG_WIDTH-1:0]     sq_i;
   logic [2*gps_pkg::MAG_WIDTH-1:0]     sq_q;
   logic [gps_pkg::I2Q2_WIDTH-1:0]      sum;
   logic [gps_pkg::I2Q2_WIDTH-1:0]      sum_early;
   logic [gps_pkg::I2Q2_WIDTH-1:0]      sum_prompt;

   // Take a new set only when idle.
   assign o_pop     = (state == gps_pkg::ENG_IDLE) && i_not_empty;
   // Operand stage of prompt and late.
   assign load_next = (state != gps_pkg::ENG_IDLE) && !sq_due && !sum_due;
   assign sum       = {1'b0, sq_i} + {1'b0, sq_q};

   always_comb begin
      case (state)
         gps_pkg::SUB_PROMPT: begin
            next_i = held.prompt_i;
            next_q = held.prompt_q;
         end
         gps_pkg::SUB_LATE: begin
            next_i = held.late_i;
            next_q = held.late_q;
         end
         default: begin
            next_i = held.early_i;
            next_q = held.early_q;
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state        <= gps_pkg::ENG_IDLE;
         sq_due       <= 1'b0;
         sum_due      <= 1'b0;
         o_i2q2_valid <= 1'b0;
      end else begin
         o_i2q2_valid <= 1'b0;
         if (o_pop) begin
            state  <= gps_pkg::SUB_EARLY;
            sq_due <= 1'b1;
         end else if (sq_due) begin
            sq_due  <= 1'b0;
            sum_due <= 1'b1;
         end else if (sum_due) begin
            sum_due <= 1'b0;
            case (state)
               gps_pkg::SUB_EARLY:  state <= gps_pkg::SUB_PROMPT;
               gps_pkg::SUB_PROMPT: state <= gps_pkg::SUB_LATE;
               default: begin
                  state        <= gps_pkg::ENG_IDLE;
                  o_i2q2_valid <= 1'b1;
               end
            endcase
         end else if (load_next) begin
            sq_due <= 1'b1;
         end
      end
   end

   // Shared operand, square and sum registers.
   always_ff @(posedge clk) begin
      if (o_pop) begin
         held <= i_head;
         op_i <= i_head.early_i;
         op_q <= i_head.early_q;
      end else if (load_next) begin
         op_i <= next_i;
         op_q <= next_q;
      end

      if (sq_due) begin
         sq_i <= op_i * op_i;
         sq_q <= op_q * op_q;
      end

      if (sum_due) begin
         case (state)
            gps_pkg::SUB_EARLY:  sum_early  <= sum;
            gps_pkg::SUB_PROMPT: sum_prompt <= sum;
            default: begin
               o_i2q2.early  <= sum_early;
               o_i2q2.prompt <= sum_prompt;
               o_i2q2.late   <= sum;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/track_history.sv
`timescale 1ns/10ps
`default_nettype none

module track_history (
   input  wire logic                                clk,
   input  wire logic                                i_arst_n,
   input  wire logic                                i_track_start,
   input  wire logic                                i_acc_done,
   input  wire logic signed [gps_pkg::ACC_WIDTH-1:0] i_acc_prompt_i,
   input  wire logic signed [gps_pkg::ACC_WIDTH-1:0] i_acc_prompt_q,
   input  wire logic                                i_tracking_ready,
   input  wire gps_pkg::loop_result_t               i_loop,
   input  wire logic                                i_track_carrier_en,
   input  wire logic                                i_track_code_en,
   output gps_pkg::track_state_t                    o_track
);

   gps_pkg::track_state_t hist;
   // The FLL's first result after entry is not trusted.
   logic                  ignore_doppler;

   assign o_track = hist;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         hist                 <= '0;
         // Seeded to one so the loops never divide by zero.
         hist.i2q2_prompt_km1 <= gps_pkg::I2Q2_ONE;
         ignore_doppler       <= 1'b1;
      end else if (i_track_start) begin
         hist                 <= '0;
         hist.i2q2_prompt_km1 <= gps_pkg::I2Q2_ONE;
         ignore_doppler       <= 1'b1;
      end else begin
         // Prompt values at k.
         if (i_acc_done) begin
            hist.prompt_i_k <= i_acc_prompt_i;
            hist.prompt_q_k <= i_acc_prompt_q;
         end

         if (i_tracking_ready) begin
            hist.prompt_i_km1    <= hist.prompt_i_k;
            hist.prompt_q_km1    <= hist.prompt_q_k;
            hist.i2q2_prompt_km1 <= i_loop.i2q2_prompt;
            hist.step_count      <= hist.step_count + 1'b1;
            ignore_doppler       <= 1'b0;

            // Carrier NCO increment.
            if (i_track_carrier_en && !ignore_doppler) begin
               hist.doppler_inc <= i_loop.doppler_inc;
            end

            // Code NCO increment.
            if (i_track_code_en) begin
               hist.code_inc <= i_loop.code_inc;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/gps_channel.sv
`timescale 1ns/10ps
`default_nettype none

module gps_channel (
   input  wire logic                  clk,
   input  wire logic                  i_arst_n,
   input  wire gps_pkg::mode_e        i_mode,
   input  wire logic                  i_data_available,
   input  wire logic                  i_acc_done,
   input  wire gps_pkg::acc_set_t     i_acc,
   input  wire logic                  i_tracking_ready,
   input  wire gps_pkg::loop_result_t i_loop,
   input  wire logic                  i_track_carrier_en,
   input  wire logic                  i_track_code_en,
   output logic                       o_feed_complete,
   output logic                       o_i2q2_valid,
   output gps_pkg::i2q2_set_t         o_i2q2,
   output logic                       o_overrun,
   output gps_pkg::track_state_t      o_track
);

   logic              track_start;
   logic              push;
   gps_pkg::mag_set_t push_set;
   logic              not_empty;
   gps_pkg::mag_set_t head;
   logic              pop;

   mode_control mode_control_i (
      .clk              (clk),
      .i_arst_n         (i_arst_n),
      .i_mode           (i_mode),
      .i_data_available (i_data_available),
      .o_track_start    (track_start),
      .o_feed_complete  (o_feed_complete)
   );

   // Magnitudes of each finished integration.
   corr_capture corr_capture_i (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_acc_done (i_acc_done),
      .i_acc      (i_acc),
      .o_push     (push),
      .o_push_set (push_set)
   );

   mag_fifo mag_fifo_i (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_clear     (track_start),
      .i_push      (push),
      .i_push_set  (push_set),
      .i_pop       (pop),
      .o_not_empty (not_empty),
      .o_head      (head),
      .o_overrun   (o_overrun)
   );

   i2q2_engine i2q2_engine_i (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_not_empty  (not_empty),
      .i_head       (head),
      .o_pop        (pop),
      .o_i2q2_valid (o_i2q2_valid),
      .o_i2q2       (o_i2q2)
   );

   // Loop history works on raw prompt accumulations.
   track_history track_history_i (
      .clk                (clk),
      .i_arst_n           (i_arst_n),
      .i_track_start      (track_start),
      .i_acc_done         (i_acc_done),
      .i_acc_prompt_i     (i_acc.prompt_i),
      .i_acc_prompt_q     (i_acc.prompt_q),
      .i_tracking_ready   (i_tracking_ready),
      .i_loop             (i_loop),
      .i_track_carrier_en (i_track_carrier_en),
      .i_track_code_en    (i_track_code_en),
      .o_track            (o_track)
   );

endmodule

`default_nettype wire

//--- verification/gps_channel_chk.sv
`timescale 1ns/10ps
`default_nettype none

module gps_channel_chk (
   input wire logic                  clk,
   input wire logic                  i_arst_n,
   input wire gps_pkg::mode_e        i_mode,
   input wire logic                  i_track_start,
   input wire logic                  i_pop,
   input wire logic                  i_feed_complete,
   input wire logic                  i_i2q2_valid,
   input wire logic                  i_overrun,
   input wire gps_pkg::track_state_t i_track
);

   gps_pkg::track_state_t cleared;
   int unsigned           fail_count = 0;

   // History right after reset or a tracking entry.
   always_comb begin
      cleared                 = '0;
      cleared.i2q2_prompt_km1 = gps_pkg::I2Q2_ONE;
   end

   a_reset_quiet: assert property (@(posedge clk)
      !i_arst_n |-> !i_feed_complete && !i_i2q2_valid && !i_overrun)
   else begin
      fail_count++;
      $error("CHECK FAILED t=%0t reset strobes got feed=%0b valid=%0b overrun=%0b exp 0",
             $time, $sampled(i_feed_complete), $sampled(i_i2q2_valid), $sampled(i_overrun));
   end

   a_reset_history: assert property (@(posedge clk) !i_arst_n |-> i_track == cleared)
   else begin
      fail_count++;
      $error("CHECK FAILED t=%0t o_track got 0x%0h exp 0x%0h", $time, $sampled(i_track), cleared);
   end

   a_feed_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_feed_complete |=> !i_feed_complete)
   else begin
      fail_count++;
      $error("CHECK FAILED t=%0t o_feed_complete got 1 exp 0", $time);
   end

   a_feed_tracking: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_feed_complete |-> $past(i_mode) == gps_pkg::MODE_TRACK)
   else begin
      fail_count++;
      $error("o_feed_complete pulsed at %0t while the channel was not tracking", $time);
   end

   // Nine cycles from pop to result.
   a_engine_latency: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_i2q2_valid == $past(i_pop, 9))
   else begin
      fail_count++;
      $error("CHECK FAILED t=%0t o_i2q2_valid got %0b exp %0b",
             $time, $sampled(i_i2q2_valid), !$sampled(i_i2q2_valid));
   end

   a_overrun_sticky: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_overrun && !i_track_start |=> i_overrun)
   else begin
      fail_count++;
      $error("CHECK FAILED t=%0t o_overrun got 0 exp 1", $time);
   end

   a_entry_clears: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_track_start |=> i_track == cleared)
   else begin
      fail_count++;
      $error("CHECK FAILED t=%0t o_track got 0x%0h exp 0x%0h", $time, $sampled(i_track), cleared);
   end

endmodule

bind gps_channel gps_channel_chk chk_i (
   .clk             (clk),
   .i_arst_n        (i_arst_n),
   .i_mode          (i_mode),
   .i_track_start   (track_start),
   .i_pop           (pop),
   .i_feed_complete (o_feed_complete),
   .i_i2q2_valid    (o_i2q2_valid),
   .i_overrun       (o_overrun),
   .i_track         (o_track)
);

`default_nettype wire

//--- verification/tb_gps_channel.sv
`timescale 1ns/10ps
`default_nettype none

module tb_gps_channel;

   logic                  clk;
   logic                  i_arst_n;
   gps_pkg::mode_e        i_mode;
   logic                  i_data_available;
   logic                  i_acc_done;
   gps_pkg::acc_set_t     i_acc;
   logic                  i_tracking_ready;
   gps_pkg::loop_result_t i_loop;
   logic                  i_track_carrier_en;
   logic                  i_track_code_en;
   logic                  o_feed_complete;
   logic                  o_i2q2_valid;
   gps_pkg::i2q2_set_t    o_i2q2;
   logic                  o_overrun;
   gps_pkg::track_state_t o_track;

   // Reference model state.
   gps_pkg::i2q2_set_t    exp_q [$];
   gps_pkg::track_state_t exp_track;
   gps_pkg::mode_e        prev_mode;
   logic                  exp_feed;
   logic                  start_due;
   logic                  ignore_doppler;
   int                    sample_count;
   int                    feed_seen = 0;
   int                    results_seen = 0;
   int                    errors = 0;
   logic [31:0]           lfsr = 32'hf29b;

   gps_channel dut_i (.*);

   always #2 clk = !clk;

   // One sample strobe every other cycle.
   always @(posedge clk) begin
      #1;
      i_data_available = !i_data_available;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ 32'hd000_0001) : (state >> 1);
   endfunction

   function automatic logic [63:0] random_bits(input int count);
      logic [63:0] bits;
      bits = '0;
      for (int b = 0; b < count; b++) begin
         lfsr    = lfsr_next(lfsr);
         bits[b] = lfsr[0];
      end
      return bits;
   endfunction

   // Absolute value, clipped to the largest positive magnitude.
   function automatic logic [gps_pkg::MAG_WIDTH-1:0] magnitude(
      input logic signed [gps_pkg::ACC_WIDTH-1:0] value
   );
      int x;
      int full_scale;
      x          = value;
      full_scale = (1 << (gps_pkg::MAG_WIDTH - 1)) - 1;
      if (x < 0) begin
         x = -x;
      end
      if (x > full_scale) begin
         x = full_scale;
      end
      return gps_pkg::MAG_WIDTH'(x);
   endfunction

   function automatic logic [gps_pkg::I2Q2_WIDTH-1:0] power_sum(
      input logic signed [gps_pkg::ACC_WIDTH-1:0] i_val,
      input logic signed [gps_pkg::ACC_WIDTH-1:0] q_val
   );
      longint mi;
      longint mq;
      mi = magnitude(i_val);
      mq = magnitude(q_val);
      return gps_pkg::I2Q2_WIDTH'(mi * mi + mq * mq);
   endfunction

   function automatic gps_pkg::i2q2_set_t expected_set(input gps_pkg::acc_set_t a);
      gps_pkg::i2q2_set_t s;
      s.early  = power_sum(a.early_i, a.early_q);
      s.prompt = power_sum(a.prompt_i, a.prompt_q);
      s.late   = power_sum(a.late_i, a.late_q);
      return s;
   endfunction

   task automatic compare_value(input string name, input logic [199:0] got,
                                input logic [199:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED t=%0t %s got 0x%0h exp 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic reset_history_model();
      exp_track                 = '0;
      exp_track.i2q2_prompt_km1 = gps_pkg::I2Q2_ONE;
      ignore_doppler            = 1'b1;
   endtask

   // Stimulus tasks enter and leave 1 ns after a rising edge.
   task automatic idle_cycles(input int count);
      repeat (count) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic drive_acc(input bit record, input bit extremes);
      gps_pkg::acc_set_t a;
      logic [63:0]       bits;
      bits     = random_bits(48);
      a[47:0]  = bits[47:0];
      bits     = random_bits(48);
      a[95:48] = bits[47:0];
      if (extremes) begin
         // Most negative value and its neighbour.
         a.early_i  = 16'sh8000;
         a.prompt_q = 16'sh8001;
      end
      i_acc      = a;
      i_acc_done = 1'b1;
      if (record) begin
         exp_q.push_back(expected_set(a));
      end
      idle_cycles(1);
      i_acc_done = 1'b0;
   endtask

   task automatic drive_loop(input bit carrier_en, input bit code_en);
      logic [63:0] bits;
      bits               = random_bits(gps_pkg::I2Q2_WIDTH);
      i_loop.i2q2_prompt = bits[gps_pkg::I2Q2_WIDTH-1:0];
      bits               = random_bits(gps_pkg::PHASE_INC_WIDTH);
      i_loop.doppler_inc = bits[gps_pkg::PHASE_INC_WIDTH-1:0];
      bits               = random_bits(gps_pkg::PHASE_INC_WIDTH);
      i_loop.code_inc    = bits[gps_pkg::PHASE_INC_WIDTH-1:0];
      i_track_carrier_en = carrier_en;
      i_track_code_en    = code_en;
      i_tracking_ready   = 1'b1;
      idle_cycles(1);
      i_tracking_ready   = 1'b0;
   endtask

   task automatic wait_for_count(input bit feeds, input int target);
      int cycles;
      int limit;
      cycles = 0;
      limit  = 4 * gps_pkg::SAMPLES_PER_ACC + 100;
      while (((feeds ? feed_seen : results_seen) < target) && (cycles < limit)) begin
         idle_cycles(1);
         cycles++;
      end
      if ((feeds ? feed_seen : results_seen) < target) begin
         errors++;
         $display("Timed out at %0t waiting for %s", $time,
                  feeds ? "o_feed_complete" : "o_i2q2_valid");
      end
   endtask

   // Outputs seen here still hold the values of the cycle just ended.
   always @(posedge clk) begin
      if (!i_arst_n) begin
         reset_history_model();
         prev_mode    = gps_pkg::MODE_IDLE;
         start_due    = 1'b0;
         exp_feed     = 1'b0;
         sample_count = 0;
      end else begin
         compare_value("o_feed_complete", o_feed_complete, exp_feed);
         compare_value("o_track", o_track, exp_track);
         if (o_feed_complete) begin
            feed_seen++;
         end
         if (o_i2q2_valid) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("Unexpected o_i2q2_valid at %0t with no set outstanding", $time);
            end else begin
               compare_value("o_i2q2", o_i2q2, exp_q.pop_front());
               results_seen++;
            end
         end

         exp_feed = 1'b0;
         if (start_due) begin
            sample_count = 0;
            reset_history_model();
         end else begin
            if (i_tracking_ready) begin
               exp_track.prompt_i_km1    = exp_track.prompt_i_k;
               exp_track.prompt_q_km1    = exp_track.prompt_q_k;
               exp_track.i2q2_prompt_km1 = i_loop.i2q2_prompt;
               exp_track.step_count      = exp_track.step_count + 1'b1;
               if (i_track_carrier_en && !ignore_doppler) begin
                  exp_track.doppler_inc = i_loop.doppler_inc;
               end
               if (i_track_code_en) begin
                  exp_track.code_inc = i_loop.code_inc;
               end
               ignore_doppler = 1'b0;
            end
            if (i_acc_done) begin
               exp_track.prompt_i_k = i_acc.prompt_i;
               exp_track.prompt_q_k = i_acc.prompt_q;
            end
            if ((i_mode == gps_pkg::MODE_TRACK) && i_data_available) begin
               sample_count++;
               if (sample_count == gps_pkg::SAMPLES_PER_ACC) begin
                  exp_feed     = 1'b1;
                  sample_count = 0;
               end
            end
         end
         start_due = (i_mode == gps_pkg::MODE_TRACK) && (prev_mode != gps_pkg::MODE_TRACK);
         prev_mode = i_mode;
      end
   end

   // Three integrations of strobes every other cycle, plus margin.
   initial begin
      #((3 * 2 * gps_pkg::SAMPLES_PER_ACC + 2000) * 4);
      $display("Watchdog expired at %0t before the test sequence finished", $time);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      int target;
      clk                = 1'b0;
      i_arst_n           = 1'b1;
      i_mode             = gps_pkg::MODE_IDLE;
      i_data_available   = 1'b0;
      i_acc_done         = 1'b0;
      i_acc              = '0;
      i_tracking_ready   = 1'b0;
      i_loop             = '0;
      i_track_carrier_en = 1'b0;
      i_track_code_en    = 1'b0;
      #1;
      i_arst_n = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      idle_cycles(4);
      compare_value("o_overrun", o_overrun, 1'b0);

      // Single sets, each followed by one loop update.
      i_mode = gps_pkg::MODE_TRACK;
      idle_cycles(4);
      for (int n = 0; n < 4; n++) begin
         target = results_seen + 1;
         drive_acc(1'b1, n == 0);
         wait_for_count(1'b0, target);
         drive_loop(n != 2, n != 1);
      end
      compare_value("o_overrun", o_overrun, 1'b0);

      // Five back to back sets, the last two are dropped.
      target = results_seen + 3;
      for (int n = 0; n < 5; n++) begin
         drive_acc(n < 3, 1'b0);
      end
      wait_for_count(1'b0, target);
      idle_cycles(30);
      compare_value("o_overrun", o_overrun, 1'b1);
      wait_for_count(1'b1, 2);

      // Leave and enter tracking again.
      i_mode = gps_pkg::MODE_IDLE;
      idle_cycles(5);
      compare_value("o_overrun", o_overrun, 1'b1);
      i_mode = gps_pkg::MODE_TRACK;
      idle_cycles(4);
      compare_value("o_overrun", o_overrun, 1'b0);
      target = results_seen + 1;
      drive_acc(1'b1, 1'b1);
      wait_for_count(1'b0, target);
      drive_loop(1'b1, 1'b1);
      drive_loop(1'b1, 1'b1);
      wait_for_count(1'b1, feed_seen + 1);
      idle_cycles(4);

      $display("Closing: %0d testbench errors, %0d assertion failures",
               errors, dut_i.chk_i.fail_count);
      if ((errors == 0) && (dut_i.chk_i.fail_count == 0)) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
design/gps_pkg.sv
design/mode_control.sv
design/corr_capture.sv
design/mag_fifo.sv
design/i2q2_engine.sv
design/track_history.sv
design/gps_channel.sv
verification/gps_channel_chk.sv
verification/tb_gps_channel.sv

//--- Makefile
# Verilator build and run of the GPS channel testbench.

VERILATOR ?= verilator
TOP       ?= tb_gps_channel
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
